// File: ll_sync_pkg.sv
/*
 * Logic-link auto-sync shared definitions
 * Delay width, sequencer states and configuration opcodes
 */

`default_nettype none

package ll_sync_pkg;

  // Width of every online delay and of the skew count
  localparam int DELAY_W = 16;

  // Link sequencer states
  // RX comes up first, TX follows once every channel is RX ready
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_RX_UP = 2'd1,
    ST_TX_UP = 2'd2,
    ST_RUN   = 2'd3
  } seq_state_t;

  // Configuration port opcodes
  // X is the RX online delay
  // Z runs from TX online to word alignment
  // Y runs from the second marker to channel alignment
  typedef enum logic [1:0] {
    OP_NOP   = 2'd0,
    OP_SET_X = 2'd1,
    OP_SET_Y = 2'd2,
    OP_SET_Z = 2'd3
  } cfg_op_t;

endpackage

`default_nettype wire

// File: level_delay.sv
/*
 * Level delay
 * Delays the rising edge of enable by a programmed cycle count,
 * drops the output as soon as enable is seen low
 */

`timescale 1ns/1ps
`default_nettype none

module level_delay (
  input  logic                          clk_wr,
  input  logic                          rst_wr_n,
  input  logic                          enable,
  input  logic [ll_sync_pkg::DELAY_W-1:0] delay_value,
  output logic                          delayed_en
);

  import ll_sync_pkg::*;

  // Cycles seen with enable high, minus one
  logic [DELAY_W-1:0] count;

  // Saturating counter
  // Cleared whenever enable is low
  always_ff @(posedge clk_wr or negedge rst_wr_n) begin
    if (!rst_wr_n) begin
      count <= '0;
    end else if (!enable) begin
      count <= '0;
    end else if (count != {DELAY_W{1'b1}}) begin
      count <= count + DELAY_W'(1);
    end
  end

  // Slow rise once the count reaches the delay, fast drop
  // Count equals k-1 on the k-th high edge, so the rise lands on edge delay_value+1
  always_ff @(posedge clk_wr or negedge rst_wr_n) begin
    if (!rst_wr_n) begin
      delayed_en <= 1'b0;
    end else if (!enable) begin
      delayed_en <= 1'b0;
    end else if (count >= delay_value) begin
      delayed_en <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: ll_auto_sync.sv
/*
 * Per-channel logic-link auto-sync
 * Delays RX and TX online, masks the user marker after word alignment
 * and lets exactly one user strobe through for channel alignment
 */

`timescale 1ns/1ps
`default_nettype none

module ll_auto_sync #(
  parameter int MARKER_WIDTH        = 1,
  parameter bit PERSISTENT_MARKER   = 1'b0,
  parameter bit PERSISTENT_STROBE   = 1'b0,
  parameter bit NO_MARKER           = 1'b0,
  parameter bit DISABLE_TX_AUTOSYNC = 1'b0,
  parameter bit DISABLE_RX_AUTOSYNC = 1'b0
) (
  input  logic                            clk_wr,
  input  logic                            rst_wr_n,
  // TX control
  input  logic                            tx_online,
  input  logic [ll_sync_pkg::DELAY_W-1:0] delay_y_value,
  input  logic [ll_sync_pkg::DELAY_W-1:0] delay_z_value,
  output logic                            tx_online_delay,
  // User marker and strobe
  input  logic [MARKER_WIDTH-1:0]         tx_mrk_userbit,
  input  logic                            tx_stb_userbit,
  output logic [MARKER_WIDTH-1:0]         tx_auto_mrk_userbit,
  output logic                            tx_auto_stb_userbit,
  // RX control
  input  logic                            rx_online,
  input  logic [ll_sync_pkg::DELAY_W-1:0] delay_x_value,
  output logic                            rx_online_delay
);

  logic z_done;
  logic y_done;
  logic y_enable;
  logic rx_x_done;
  logic mrk_seen;
  logic first_mrk;
  logic first_stb;
  logic second_mrk;

  ////////////////////////////////////////////////////////////////////////////
  // Online delays
  ////////////////////////////////////////////////////////////////////////////

  // Z: TX online until word alignment, user marker stops here
  level_delay level_delay_z (
    .clk_wr      (clk_wr),
    .rst_wr_n    (rst_wr_n),
    .enable      (tx_online),
    .delay_value (delay_z_value),
    .delayed_en  (z_done)
  );

  // Y: second marker until channel alignment done
  assign y_enable = z_done & second_mrk;

  level_delay level_delay_y (
    .clk_wr      (clk_wr),
    .rst_wr_n    (rst_wr_n),
    .enable      (y_enable),
    .delay_value (delay_y_value),
    .delayed_en  (y_done)
  );

  // X: RX online delay
  level_delay level_delay_x (
    .clk_wr      (clk_wr),
    .rst_wr_n    (rst_wr_n),
    .enable      (rx_online),
    .delay_value (delay_x_value),
    .delayed_en  (rx_x_done)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Marker and strobe tracking
  ////////////////////////////////////////////////////////////////////////////

  // Without a marker the strobe stands in for it
  assign mrk_seen = NO_MARKER ? tx_stb_userbit : (|tx_mrk_userbit);

  // First marker after Z, dropped with Z
  always_ff @(posedge clk_wr or negedge rst_wr_n) begin
    if (!rst_wr_n) begin
      first_mrk <= 1'b0;
    end else if (!z_done) begin
      first_mrk <= 1'b0;
    end else if (mrk_seen) begin
      first_mrk <= 1'b1;
    end
  end

  // The single strobe that follows the first marker
  always_ff @(posedge clk_wr or negedge rst_wr_n) begin
    if (!rst_wr_n) begin
      first_stb <= 1'b0;
    end else if (!first_mrk) begin
      first_stb <= 1'b0;
    end else if (tx_stb_userbit) begin
      first_stb <= 1'b1;
    end
  end

  // Second marker closes the strobe window
  // In no-marker mode the next strobe does it
  always_ff @(posedge clk_wr or negedge rst_wr_n) begin
    if (!rst_wr_n) begin
      second_mrk <= 1'b0;
    end else if (!first_mrk) begin
      second_mrk <= 1'b0;
    end else if (NO_MARKER ? tx_stb_userbit : (first_stb & (|tx_mrk_userbit))) begin
      second_mrk <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output gating
  ////////////////////////////////////////////////////////////////////////////

  // User marker masked once word alignment has started
  assign tx_auto_mrk_userbit = (DISABLE_TX_AUTOSYNC || PERSISTENT_MARKER) ? tx_mrk_userbit :
                               (tx_mrk_userbit & {MARKER_WIDTH{~first_mrk}});

  // One strobe word between first and second marker
  assign tx_auto_stb_userbit = (DISABLE_TX_AUTOSYNC || PERSISTENT_STROBE) ? tx_stb_userbit :
                               (tx_stb_userbit & first_mrk & ~second_mrk);

  // Delayed onlines, or straight through when bypassed
  assign tx_online_delay = DISABLE_TX_AUTOSYNC ? tx_online : y_done;
  assign rx_online_delay = DISABLE_RX_AUTOSYNC ? rx_online : rx_x_done;

endmodule

`default_nettype wire

// File: ll_sync_seq.sv
/*
 * Link online sequencer
 * Holds the per-channel X, Y and Z delays and raises RX online,
 * then TX online, for all channels
 */

`timescale 1ns/1ps
`default_nettype none

module ll_sync_seq #(
  parameter  int NUM_CH = 4,
  localparam int CH_W   = (NUM_CH > 1) ? $clog2(NUM_CH) : 1
) (
  input  logic                                   clk_wr,
  input  logic                                   rst_wr_n,
  input  logic                                   link_en,
  input  logic                                   cfg_wr,
  input  ll_sync_pkg::cfg_op_t                   cfg_op,
  input  logic [CH_W-1:0]                        cfg_chan,
  input  logic [ll_sync_pkg::DELAY_W-1:0]        cfg_data,
  input  logic                                   rx_all_ready,
  input  logic                                   tx_all_ready,
  output logic [NUM_CH-1:0]                      tx_online,
  output logic [NUM_CH-1:0]                      rx_online,
  output logic [NUM_CH*ll_sync_pkg::DELAY_W-1:0] delay_x,
  output logic [NUM_CH*ll_sync_pkg::DELAY_W-1:0] delay_y,
  output logic [NUM_CH*ll_sync_pkg::DELAY_W-1:0] delay_z,
  output ll_sync_pkg::seq_state_t                link_state
);

  import ll_sync_pkg::*;

  seq_state_t state;
  seq_state_t state_nxt;
  logic       cfg_ok;

  // Delays only change while the link is down
  assign cfg_ok = cfg_wr & (state == ST_IDLE);

  ////////////////////////////////////////////////////////////////////////////
  // Per-channel delay registers
  ////////////////////////////////////////////////////////////////////////////

  for (genvar g = 0; g < NUM_CH; g++) begin : g_dly
    always_ff @(posedge clk_wr or negedge rst_wr_n) begin
      if (!rst_wr_n) begin
        delay_x[g*DELAY_W +: DELAY_W] <= '0;
        delay_y[g*DELAY_W +: DELAY_W] <= '0;
        delay_z[g*DELAY_W +: DELAY_W] <= '0;
      end else if (cfg_ok && (cfg_chan == CH_W'(g))) begin
        case (cfg_op)
          OP_SET_X: delay_x[g*DELAY_W +: DELAY_W] <= cfg_data;
          OP_SET_Y: delay_y[g*DELAY_W +: DELAY_W] <= cfg_data;
          OP_SET_Z: delay_z[g*DELAY_W +: DELAY_W] <= cfg_data;
          default: ;
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Online FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    if (!link_en) begin
      // Link drop wins from any state
      state_nxt = ST_IDLE;
    end else begin
      case (state)
        ST_IDLE:  state_nxt = ST_RX_UP;
        ST_RX_UP: if (rx_all_ready) state_nxt = ST_TX_UP;
        ST_TX_UP: if (tx_all_ready) state_nxt = ST_RUN;
        default:  state_nxt = ST_RUN;
      endcase
    end
  end

  always_ff @(posedge clk_wr or negedge rst_wr_n) begin
    if (!rst_wr_n) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Onlines decode straight from the state register
  assign rx_online  = {NUM_CH{state != ST_IDLE}};
  assign tx_online  = {NUM_CH{(state == ST_TX_UP) || (state == ST_RUN)}};
  assign link_state = state;

endmodule

`default_nettype wire

// File: ll_sync_collect.sv
/*
 * Link ready collector
 * Combines per-channel delayed onlines into link ready flags and
 * counts the TX skew between first and last channel
 */

`timescale 1ns/1ps
`default_nettype none

module ll_sync_collect #(
  parameter int NUM_CH = 4
) (
  input  logic                            clk_wr,
  input  logic                            rst_wr_n,
  input  logic [NUM_CH-1:0]               tx_online_delay,
  input  logic [NUM_CH-1:0]               rx_online_delay,
  output logic                            tx_all_ready,
  output logic                            rx_all_ready,
  output logic [ll_sync_pkg::DELAY_W-1:0] tx_skew
);

  import ll_sync_pkg::*;

  logic tx_any;
  logic tx_all;
  logic skew_done;

  assign tx_any = |tx_online_delay;
  assign tx_all = &tx_online_delay;

  // Ready flags, one cycle after the last channel
  always_ff @(posedge clk_wr or negedge rst_wr_n) begin
    if (!rst_wr_n) begin
      tx_all_ready <= 1'b0;
      rx_all_ready <= 1'b0;
    end else begin
      tx_all_ready <= tx_all;
      rx_all_ready <= &rx_online_delay;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // TX skew
  ////////////////////////////////////////////////////////////////////////////

  // Count cycles with some but not all channels online
  // Frozen once all are up, cleared when none are
  always_ff @(posedge clk_wr or negedge rst_wr_n) begin
    if (!rst_wr_n) begin
      tx_skew   <= '0;
      skew_done <= 1'b0;
    end else if (!tx_any) begin
      tx_skew   <= '0;
      skew_done <= 1'b0;
    end else if (tx_all) begin
      skew_done <= 1'b1;
    end else if (!skew_done && (tx_skew != {DELAY_W{1'b1}})) begin
      tx_skew <= tx_skew + DELAY_W'(1);
    end
  end

endmodule

`default_nettype wire

// File: ll_sync_top.sv
/*
 * Multi-channel logic-link auto-sync top
 * Sequencer, one auto-sync block per channel and the ready collector
 */

`timescale 1ns/1ps
`default_nettype none

module ll_sync_top #(
  parameter  int NUM_CH              = 4,
  parameter  int MARKER_WIDTH        = 1,
  parameter  bit PERSISTENT_MARKER   = 1'b0,
  parameter  bit PERSISTENT_STROBE   = 1'b0,
  parameter  bit NO_MARKER           = 1'b0,
  parameter  bit DISABLE_TX_AUTOSYNC = 1'b0,
  parameter  bit DISABLE_RX_AUTOSYNC = 1'b0,
  localparam int CH_W                = (NUM_CH > 1) ? $clog2(NUM_CH) : 1
) (
  input  logic                             clk_wr,
  input  logic                             rst_wr_n,
  input  logic                             link_en,
  // Configuration port
  input  logic                             cfg_wr,
  input  ll_sync_pkg::cfg_op_t             cfg_op,
  input  logic [CH_W-1:0]                  cfg_chan,
  input  logic [ll_sync_pkg::DELAY_W-1:0]  cfg_data,
  // User bits, one slice per channel
  input  logic [NUM_CH*MARKER_WIDTH-1:0]   tx_mrk_userbit,
  input  logic [NUM_CH-1:0]                tx_stb_userbit,
  output logic [NUM_CH*MARKER_WIDTH-1:0]   tx_auto_mrk_userbit,
  output logic [NUM_CH-1:0]                tx_auto_stb_userbit,
  // Link status
  output logic [NUM_CH-1:0]                tx_online_delay,
  output logic [NUM_CH-1:0]                rx_online_delay,
  output logic                             tx_all_ready,
  output logic                             rx_all_ready,
  output ll_sync_pkg::seq_state_t          link_state,
  output logic [ll_sync_pkg::DELAY_W-1:0]  tx_skew
);

  import ll_sync_pkg::*;

  logic [NUM_CH-1:0]         tx_online;
  logic [NUM_CH-1:0]         rx_online;
  logic [NUM_CH*DELAY_W-1:0] delay_x;
  logic [NUM_CH*DELAY_W-1:0] delay_y;
  logic [NUM_CH*DELAY_W-1:0] delay_z;

  ll_sync_seq #(.NUM_CH(NUM_CH)) ll_sync_seq_inst (
    .clk_wr       (clk_wr),
    .rst_wr_n     (rst_wr_n),
    .link_en      (link_en),
    .cfg_wr       (cfg_wr),
    .cfg_op       (cfg_op),
    .cfg_chan     (cfg_chan),
    .cfg_data     (cfg_data),
    .rx_all_ready (rx_all_ready),
    .tx_all_ready (tx_all_ready),
    .tx_online    (tx_online),
    .rx_online    (rx_online),
    .delay_x      (delay_x),
    .delay_y      (delay_y),
    .delay_z      (delay_z),
    .link_state   (link_state)
  );

  // One auto-sync block per channel
  for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_ch
    ll_auto_sync #(
      .MARKER_WIDTH        (MARKER_WIDTH),
      .PERSISTENT_MARKER   (PERSISTENT_MARKER),
      .PERSISTENT_STROBE   (PERSISTENT_STROBE),
      .NO_MARKER           (NO_MARKER),
      .DISABLE_TX_AUTOSYNC (DISABLE_TX_AUTOSYNC),
      .DISABLE_RX_AUTOSYNC (DISABLE_RX_AUTOSYNC)
    ) ll_auto_sync_inst (
      .clk_wr              (clk_wr),
      .rst_wr_n            (rst_wr_n),
      .tx_online           (tx_online[ch]),
      .delay_y_value       (delay_y[ch*DELAY_W +: DELAY_W]),
      .delay_z_value       (delay_z[ch*DELAY_W +: DELAY_W]),
      .tx_online_delay     (tx_online_delay[ch]),
      .tx_mrk_userbit      (tx_mrk_userbit[ch*MARKER_WIDTH +: MARKER_WIDTH]),
      .tx_stb_userbit      (tx_stb_userbit[ch]),
      .tx_auto_mrk_userbit (tx_auto_mrk_userbit[ch*MARKER_WIDTH +: MARKER_WIDTH]),
      .tx_auto_stb_userbit (tx_auto_stb_userbit[ch]),
      .rx_online           (rx_online[ch]),
      .delay_x_value       (delay_x[ch*DELAY_W +: DELAY_W]),
      .rx_online_delay     (rx_online_delay[ch])
    );
  end

  ll_sync_collect #(.NUM_CH(NUM_CH)) ll_sync_collect_inst (
    .clk_wr          (clk_wr),
    .rst_wr_n        (rst_wr_n),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_all_ready    (tx_all_ready),
    .rx_all_ready    (rx_all_ready),
    .tx_skew         (tx_skew)
  );

endmodule

`default_nettype wire

// File: tb_clkgen.sv
/*
 * Testbench clock and reset
 * Free running clk_wr and an active-low reset held for a few cycles
 */

`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter int PERIOD_NS  = 100,
  parameter int RST_CYCLES = 4
) (
  output logic clk_wr,
  output logic rst_wr_n
);

  // Clock starts low, first rising edge at half a period
  initial begin
    clk_wr = 1'b0;
    forever #(PERIOD_NS / 2) clk_wr = ~clk_wr;
  end

  // Release just after an edge so nothing races the release
  initial begin
    rst_wr_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_wr);
    #1 rst_wr_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: ll_sync_asserts.sv
/*
 * Bound checks on the auto-sync top
 * Online ordering, idle exit and the single alignment strobe per channel
 */

`timescale 1ns/1ps
`default_nettype none

module ll_sync_asserts #(
  parameter int NUM_CH = 4
) (
  input  logic                    clk_wr,
  input  logic                    rst_wr_n,
  input  logic                    link_en,
  input  logic [NUM_CH-1:0]       tx_online,
  input  logic [NUM_CH-1:0]       rx_online_delay,
  input  logic [NUM_CH-1:0]       tx_auto_stb_userbit,
  input  ll_sync_pkg::seq_state_t link_state
);

  import ll_sync_pkg::*;

  logic              link_up;
  logic [NUM_CH-1:0] stb_seen;
  int                fail_cnt = 0;

  assign link_up = (link_state != ST_IDLE);

  // Channels that already let their strobe through in this link-up
  always_ff @(posedge clk_wr or negedge rst_wr_n) begin
    if (!rst_wr_n) begin
      stb_seen <= '0;
    end else if (!link_up) begin
      stb_seen <= '0;
    end else begin
      stb_seen <= stb_seen | tx_auto_stb_userbit;
    end
  end

  // TX online only once RX is up on that channel
  tx_needs_rx: assert property (@(posedge clk_wr) disable iff (!rst_wr_n)
    (tx_online & ~rx_online_delay) == '0)
    else begin
      fail_cnt++;
      $error("tx_online high on a channel with rx_online_delay low");
    end

  // Idle is left only on a link request
  idle_exit: assert property (@(posedge clk_wr) disable iff (!rst_wr_n)
    (link_state == ST_IDLE && !link_en) |=> (link_state == ST_IDLE))
    else begin
      fail_cnt++;
      $error("link_state left ST_IDLE with link_en low");
    end

  // At most one strobe per channel while the link is up
  one_strobe: assert property (@(posedge clk_wr) disable iff (!rst_wr_n)
    link_up |-> ((stb_seen & tx_auto_stb_userbit) == '0))
    else begin
      fail_cnt++;
      $error("second tx_auto_stb_userbit pulse in one link-up");
    end

endmodule

bind ll_sync_top ll_sync_asserts #(.NUM_CH(NUM_CH)) ll_sync_asserts_inst (
  .clk_wr              (clk_wr),
  .rst_wr_n            (rst_wr_n),
  .link_en             (link_en),
  .tx_online           (tx_online),
  .rx_online_delay     (rx_online_delay),
  .tx_auto_stb_userbit (tx_auto_stb_userbit),
  .link_state          (link_state)
);

`default_nettype wire

// File: ll_sync_tb.sv
/*
 * Testbench for the multi-channel logic-link auto-sync
 * Random delays and marker streams, cycle model of the link rules,
 * per-cycle output compare and one report line per test
 */

`timescale 1ns/1ps
`default_nettype none

module ll_sync_tb;

  import ll_sync_pkg::*;

  localparam int NUM_CH       = 4;
  localparam int MARKER_WIDTH = 1;
  localparam int CH_W         = 2;
  localparam int MRK_PERIOD   = 8;

  // Wait conditions
  localparam int W_RESET      = 0;
  localparam int W_RX_READY   = 1;
  localparam int W_FIRST_MRK  = 2;
  localparam int W_SECOND_MRK = 3;
  localparam int W_RUN        = 4;
  localparam int W_QUIET      = 5;

  logic                           clk_wr;
  logic                           rst_wr_n;
  logic                           link_en;
  logic                           cfg_wr;
  cfg_op_t                        cfg_op;
  logic [CH_W-1:0]                cfg_chan;
  logic [DELAY_W-1:0]             cfg_data;
  logic [NUM_CH*MARKER_WIDTH-1:0] tx_mrk_userbit;
  logic [NUM_CH-1:0]              tx_stb_userbit;
  logic [NUM_CH*MARKER_WIDTH-1:0] tx_auto_mrk_userbit;
  logic [NUM_CH-1:0]              tx_auto_stb_userbit;
  logic [NUM_CH-1:0]              tx_online_delay;
  logic [NUM_CH-1:0]              rx_online_delay;
  logic                           tx_all_ready;
  logic                           rx_all_ready;
  seq_state_t                     link_state;
  logic [DELAY_W-1:0]             tx_skew;

  // Bookkeeping
  int cyc;
  int err_cnt;
  int chk_cnt;
  int tests_run;
  int tests_failed;
  int test_err_base;
  int rx_rise [NUM_CH];
  int tx_rise [NUM_CH];
  int stb_cnt [NUM_CH];
  logic [NUM_CH-1:0] prev_rx;
  logic [NUM_CH-1:0] prev_tx;
  logic              timed_out;

  // Stimulus state
  logic               stream_en;
  int                 ph [NUM_CH];
  int                 stb_ph [NUM_CH];
  logic [DELAY_W-1:0] cfg_x [NUM_CH];

  // Reference model state
  seq_state_t        m_state;
  int                m_dx [NUM_CH];
  int                m_dy [NUM_CH];
  int                m_dz [NUM_CH];
  int                m_cx [NUM_CH];
  int                m_cy [NUM_CH];
  int                m_cz [NUM_CH];
  logic [NUM_CH-1:0] m_xd;
  logic [NUM_CH-1:0] m_yd;
  logic [NUM_CH-1:0] m_zd;
  logic [NUM_CH-1:0] m_fm;
  logic [NUM_CH-1:0] m_fs;
  logic [NUM_CH-1:0] m_sm;
  logic              m_rx_rdy;
  logic              m_tx_rdy;
  logic              m_skew_done;
  int                m_skew;

  tb_clkgen #(.PERIOD_NS(100), .RST_CYCLES(4)) tb_clkgen_inst (
    .clk_wr   (clk_wr),
    .rst_wr_n (rst_wr_n)
  );

  ll_sync_top #(
    .NUM_CH              (NUM_CH),
    .MARKER_WIDTH        (MARKER_WIDTH),
    .PERSISTENT_MARKER   (1'b0),
    .PERSISTENT_STROBE   (1'b0),
    .NO_MARKER           (1'b0),
    .DISABLE_TX_AUTOSYNC (1'b0),
    .DISABLE_RX_AUTOSYNC (1'b0)
  ) ll_sync_top_inst (
    .clk_wr              (clk_wr),
    .rst_wr_n            (rst_wr_n),
    .link_en             (link_en),
    .cfg_wr              (cfg_wr),
    .cfg_op              (cfg_op),
    .cfg_chan            (cfg_chan),
    .cfg_data            (cfg_data),
    .tx_mrk_userbit      (tx_mrk_userbit),
    .tx_stb_userbit      (tx_stb_userbit),
    .tx_auto_mrk_userbit (tx_auto_mrk_userbit),
    .tx_auto_stb_userbit (tx_auto_stb_userbit),
    .tx_online_delay     (tx_online_delay),
    .rx_online_delay     (rx_online_delay),
    .tx_all_ready        (tx_all_ready),
    .rx_all_ready        (rx_all_ready),
    .link_state          (link_state),
    .tx_skew             (tx_skew)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  task automatic model_reset();
    m_state     = ST_IDLE;
    m_xd        = '0;
    m_yd        = '0;
    m_zd        = '0;
    m_fm        = '0;
    m_fs        = '0;
    m_sm        = '0;
    m_rx_rdy    = 1'b0;
    m_tx_rdy    = 1'b0;
    m_skew_done = 1'b0;
    m_skew      = 0;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      m_dx[ch] = 0;
      m_dy[ch] = 0;
      m_dz[ch] = 0;
      m_cx[ch] = 0;
      m_cy[ch] = 0;
      m_cz[ch] = 0;
    end
  endtask

  // One rising edge, every update taken from the values before the edge
  task automatic model_step();
    seq_state_t        st_old;
    logic              rx_rdy_old;
    logic              tx_rdy_old;
    logic              rx_on;
    logic              tx_on;
    logic [NUM_CH-1:0] y_en;
    logic [NUM_CH-1:0] xd_old;
    logic [NUM_CH-1:0] yd_old;
    logic [NUM_CH-1:0] fm_old;
    logic [NUM_CH-1:0] fs_old;
    st_old     = m_state;
    rx_rdy_old = m_rx_rdy;
    tx_rdy_old = m_tx_rdy;
    rx_on      = (m_state != ST_IDLE);
    tx_on      = (m_state == ST_TX_UP) || (m_state == ST_RUN);
    y_en       = m_zd & m_sm;
    xd_old     = m_xd;
    yd_old     = m_yd;
    fm_old     = m_fm;
    fs_old     = m_fs;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      // Strobe window flags follow the first marker
      if (!fm_old[ch]) begin
        m_fs[ch] = 1'b0;
        m_sm[ch] = 1'b0;
      end else begin
        if (tx_stb_userbit[ch]) m_fs[ch] = 1'b1;
        if (fs_old[ch] && tx_mrk_userbit[ch]) m_sm[ch] = 1'b1;
      end
      // First marker only counts once Z is done
      if (!m_zd[ch]) m_fm[ch] = 1'b0;
      else if (tx_mrk_userbit[ch]) m_fm[ch] = 1'b1;
      // Delay d rises on the (d+1)-th edge with enable high
      if (rx_on) begin
        m_cx[ch]++;
        if (m_cx[ch] > m_dx[ch]) m_xd[ch] = 1'b1;
      end else begin
        m_cx[ch] = 0;
        m_xd[ch] = 1'b0;
      end
      if (tx_on) begin
        m_cz[ch]++;
        if (m_cz[ch] > m_dz[ch]) m_zd[ch] = 1'b1;
      end else begin
        m_cz[ch] = 0;
        m_zd[ch] = 1'b0;
      end
      if (y_en[ch]) begin
        m_cy[ch]++;
        if (m_cy[ch] > m_dy[ch]) m_yd[ch] = 1'b1;
      end else begin
        m_cy[ch] = 0;
        m_yd[ch] = 1'b0;
      end
    end
    // Collector
    m_rx_rdy = &xd_old;
    m_tx_rdy = &yd_old;
    if (yd_old == '0) begin
      m_skew      = 0;
      m_skew_done = 1'b0;
    end else if (&yd_old) begin
      m_skew_done = 1'b1;
    end else if (!m_skew_done) begin
      m_skew++;
    end
    // Sequencer
    if (!link_en) m_state = ST_IDLE;
    else if (st_old == ST_IDLE) m_state = ST_RX_UP;
    else if (st_old == ST_RX_UP && rx_rdy_old) m_state = ST_TX_UP;
    else if (st_old == ST_TX_UP && tx_rdy_old) m_state = ST_RUN;
    // Config writes only land in idle
    if (cfg_wr && st_old == ST_IDLE) begin
      if (cfg_op == OP_SET_X) m_dx[cfg_chan] = cfg_data;
      if (cfg_op == OP_SET_Y) m_dy[cfg_chan] = cfg_data;
      if (cfg_op == OP_SET_Z) m_dz[cfg_chan] = cfg_data;
    end
  endtask

  always @(posedge clk_wr or negedge rst_wr_n) begin
    if (!rst_wr_n) begin
      model_reset();
    end else begin
      model_step();
    end
  end

  always @(posedge clk_wr) begin
    cyc <= cyc + 1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and checking helpers
  ////////////////////////////////////////////////////////////////////////////

  // Periodic marker with one strobe in between, random phase per channel
  always @(posedge clk_wr) begin
    #1;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      ph[ch] = (ph[ch] + 1) % MRK_PERIOD;
      tx_mrk_userbit[ch] = stream_en && (ph[ch] == 0);
      tx_stb_userbit[ch] = stream_en && (ph[ch] == stb_ph[ch]);
    end
  end

  task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %0t ns %s exp %0h got %0h", $time, name, exp, got);
    end
  endtask

  // Outputs compared mid-cycle, well clear of edges and input changes
  always @(negedge clk_wr) begin
    if (rst_wr_n) begin
      check_val("rx_online_delay", rx_online_delay, m_xd);
      check_val("tx_online_delay", tx_online_delay, m_yd);
      check_val("tx_auto_mrk_userbit", tx_auto_mrk_userbit, tx_mrk_userbit & ~m_fm);
      check_val("tx_auto_stb_userbit", tx_auto_stb_userbit,
                tx_stb_userbit & m_fm & ~m_sm);
      check_val("rx_all_ready", rx_all_ready, m_rx_rdy);
      check_val("tx_all_ready", tx_all_ready, m_tx_rdy);
      check_val("link_state", 32'(link_state), 32'(m_state));
      check_val("tx_skew", tx_skew, m_skew);
      for (int ch = 0; ch < NUM_CH; ch++) begin
        if (rx_online_delay[ch] && !prev_rx[ch]) rx_rise[ch] = cyc;
        // TX rise cycles come from the model
        if (m_yd[ch] && !prev_tx[ch]) tx_rise[ch] = cyc;
        if (tx_auto_stb_userbit[ch]) stb_cnt[ch]++;
      end
      prev_rx = rx_online_delay;
      prev_tx = m_yd;
    end
  end

  task automatic tick();
    @(posedge clk_wr);
    #1;
  endtask

  function automatic bit cond_met(int kind);
    case (kind)
      W_RESET:      return rst_wr_n;
      W_RX_READY:   return rx_all_ready;
      W_FIRST_MRK:  return &m_fm;
      W_SECOND_MRK: return &m_sm;
      W_RUN:        return link_state == ST_RUN;
      W_QUIET:      return (link_state == ST_IDLE) && !rx_all_ready && !tx_all_ready &&
                           (tx_skew == '0) && (rx_online_delay == '0) &&
                           (tx_online_delay == '0);
      default:      return 1'b0;
    endcase
  endfunction

  // After a timeout every later wait falls straight through
  task automatic wait_until(int kind, int limit, string what);
    int n;
    n = 0;
    while (!timed_out && !cond_met(kind) && n < limit) begin
      tick();
      n++;
    end
    if (!timed_out && !cond_met(kind)) begin
      timed_out = 1'b1;
      err_cnt++;
      $display("Timeout after %0d cycles waiting for %s", limit, what);
    end
  endtask

  task automatic cfg_write(cfg_op_t op, int ch, logic [DELAY_W-1:0] data);
    cfg_wr   = 1'b1;
    cfg_op   = op;
    cfg_chan = CH_W'(ch);
    cfg_data = data;
    tick();
    cfg_wr   = 1'b0;
    cfg_op   = OP_NOP;
  endtask

  // Skew is the distance between first and last TX rise
  task automatic check_skew();
    int lo;
    int hi;
    lo = tx_rise[0];
    hi = tx_rise[0];
    for (int ch = 1; ch < NUM_CH; ch++) begin
      if (tx_rise[ch] < lo) lo = tx_rise[ch];
      if (tx_rise[ch] > hi) hi = tx_rise[ch];
    end
    check_val("tx_skew span", tx_skew, hi - lo);
  endtask

  task automatic check_one_strobe();
    for (int ch = 0; ch < NUM_CH; ch++) begin
      check_val($sformatf("tx_auto_stb_userbit[%0d] pulses", ch), stb_cnt[ch], 1);
    end
  endtask

  task automatic end_test(string name);
    tests_run++;
    if (err_cnt == test_err_base) begin
      $display("Test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: %0d errors", tests_run, name, err_cnt - test_err_base);
    end
    test_err_base = err_cnt;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int link_cyc;
    void'($urandom(32'h54b8));
    link_en        = 1'b0;
    cfg_wr         = 1'b0;
    cfg_op         = OP_NOP;
    cfg_chan       = '0;
    cfg_data       = '0;
    tx_mrk_userbit = '0;
    tx_stb_userbit = '0;
    stream_en      = 1'b0;
    cyc            = 0;
    err_cnt        = 0;
    chk_cnt        = 0;
    tests_run      = 0;
    tests_failed   = 0;
    test_err_base  = 0;
    prev_rx        = '0;
    prev_tx        = '0;
    timed_out      = 1'b0;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      ph[ch]      = $urandom % MRK_PERIOD;
      stb_ph[ch]  = 1 + ($urandom % (MRK_PERIOD - 1));
      stb_cnt[ch] = 0;
      rx_rise[ch] = 0;
      tx_rise[ch] = 0;
    end
    wait_until(W_RESET, 20, "reset release");
    tick();

    // 1: RX online delays
    for (int ch = 0; ch < NUM_CH; ch++) begin
      cfg_x[ch] = DELAY_W'($urandom % 16);
      cfg_write(OP_SET_X, ch, cfg_x[ch]);
      cfg_write(OP_SET_Y, ch, DELAY_W'($urandom % 16));
      cfg_write(OP_SET_Z, ch, DELAY_W'($urandom % 16));
    end
    link_cyc = cyc;
    link_en  = 1'b1;
    wait_until(W_RX_READY, 100, "rx_all_ready");
    // Link seen at the next edge, X counts from the one after
    for (int ch = 0; ch < NUM_CH; ch++) begin
      check_val($sformatf("rx_online_delay[%0d] rise cycle", ch), rx_rise[ch],
                link_cyc + 2 + cfg_x[ch]);
    end
    end_test("rx online delays");

    // 2: marker masking after word alignment
    stream_en = 1'b1;
    wait_until(W_FIRST_MRK, 200, "first marker on all channels");
    end_test("marker masking");

    // 3: one strobe per channel in the alignment window
    wait_until(W_SECOND_MRK, 200, "second marker on all channels");
    check_one_strobe();
    end_test("single strobe");

    // 4: TX online, ready and skew
    wait_until(W_RUN, 200, "link_state ST_RUN");
    check_val("tx_all_ready", tx_all_ready, 1);
    check_skew();
    end_test("tx online and skew");

    // 5: writes outside idle are dropped, relink uses the new delays
    for (int ch = 0; ch < NUM_CH; ch++) begin
      cfg_write(OP_SET_X, ch, DELAY_W'($urandom % 65536));
      cfg_write(OP_SET_Y, ch, DELAY_W'($urandom % 65536));
      cfg_write(OP_SET_Z, ch, DELAY_W'($urandom % 65536));
    end
    check_val("link_state", 32'(link_state), 32'(ST_RUN));
    link_en = 1'b0;
    wait_until(W_QUIET, 50, "link idle with all onlines low");
    for (int ch = 0; ch < NUM_CH; ch++) begin
      cfg_write(OP_SET_Y, ch, DELAY_W'($urandom % 16));
      cfg_write(OP_SET_Z, ch, DELAY_W'($urandom % 16));
      stb_cnt[ch] = 0;
    end
    link_en = 1'b1;
    wait_until(W_RUN, 400, "link_state ST_RUN after relink");
    check_one_strobe();
    check_skew();
    end_test("relink");

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
             tests_run, tests_failed, chk_cnt, err_cnt,
             ll_sync_top_inst.ll_sync_asserts_inst.fail_cnt);
    if (err_cnt == 0 && ll_sync_top_inst.ll_sync_asserts_inst.fail_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
ll_sync_pkg.sv
level_delay.sv
ll_auto_sync.sv
ll_sync_seq.sv
ll_sync_collect.sv
ll_sync_top.sv
tb_clkgen.sv
ll_sync_asserts.sv
ll_sync_tb.sv
